// ==== udp_echo.f ====
+incdir+include
logic/udp_echo_pkg.sv
logic/frame_header_decode.sv
logic/echo_port_execute.sv
logic/reply_frame_result.sv
logic/udp_echo_top.sv
test/udp_echo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the UDP echo testbench
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module udp_echo_tb -f udp_echo.f \
    -Mdir obj_dir -o udp_echo_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/udp_echo_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0

// ==== test/udp_echo_tb.sv ====
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module udp_echo_tb;

    localparam int READY_TIMEOUT = 20000;
    localparam int DRAIN_TIMEOUT = 60000;
    localparam logic [31:0] MY_IP = `LOCAL_IP;

    // One frame of stimulus and whether a reply is expected
    typedef struct packed {
        udp_echo_pkg::mac_addr_t src_mac;
        udp_echo_pkg::ip_addr_t  src_ip;
        udp_echo_pkg::ip_addr_t  dst_ip;
        udp_echo_pkg::udp_port_t src_port;
        udp_echo_pkg::udp_port_t dst_port;
        logic [15:0]             ethertype;
        logic [7:0]              protocol;
        udp_echo_pkg::len16_t    pay_len;
        udp_echo_pkg::byte_t     first_byte;
        logic                    echo;
    } frame_row_t;

    logic                     clk_system;
    logic                     rst;
    udp_echo_pkg::byte_beat_t in_beat;
    logic                     in_valid;
    logic                     in_ready;
    udp_echo_pkg::byte_beat_t out_beat;
    logic                     out_valid;
    logic                     out_ready;

    frame_row_t               rows [$];
    udp_echo_pkg::byte_beat_t tx_q [$];
    udp_echo_pkg::byte_beat_t exp_q [$];
    logic [31:0]              lfsr;
    int                       checks;
    int                       value_errors;
    int                       other_errors;

    udp_echo_top dut (
        .clk_system(clk_system), .rst(rst),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial begin
        clk_system = 1'b0;
        forever #20 clk_system = ~clk_system;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] ones_fold(input logic [31:0] s);
        logic [31:0] t;
        t = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        t = {16'h0, t[15:0]} + {16'h0, t[31:16]};
        return t[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic add_row(input logic [47:0] mac, input logic [31:0] sip,
                           input logic [31:0] dip, input logic [15:0] sport,
                           input logic [15:0] dport, input logic [15:0] etype,
                           input logic [7:0] proto, input logic [15:0] len,
                           input logic [7:0] first, input logic echo);
        rows.push_back({mac, sip, dip, sport, dport, etype, proto, len, first, echo});
    endtask

    // Low n bytes of v, most significant first
    task automatic push_field(input logic [95:0] v, input int n, input bit to_exp);
        udp_echo_pkg::byte_beat_t b;
        for (int k = n - 1; k >= 0; k--) begin
            b.data = v[8*k +: 8];
            b.last = 1'b0;
            if (to_exp) exp_q.push_back(b);
            else tx_q.push_back(b);
        end
    endtask

    task automatic send_frame(input frame_row_t r, input int idx, output bit ok);
        udp_echo_pkg::byte_beat_t b;
        logic [15:0]              ip_len;
        logic [159:0]             ip_words;
        logic [31:0]              sum;
        int                       wait_cnt;
        ip_len = 16'd28 + r.pay_len;
        tx_q.delete();
        push_field({`LOCAL_MAC, r.src_mac}, 12, 0);
        push_field({r.ethertype, 16'h4500, ip_len, 16'h1234}, 8, 0);
        push_field({16'h4000, 8'd128, r.protocol, 16'h0000, r.src_ip[31:16]}, 8, 0);
        push_field({r.src_ip[15:0], r.dst_ip, r.src_port}, 8, 0);
        push_field({r.dst_port, ip_len - 16'd20, 16'h0000}, 6, 0);
        if (r.echo) begin
            // Reply IP header with the checksum field taken as zero
            ip_words = {16'h4500, ip_len, 32'h0000_0000, `REPLY_TTL, `IP_PROTO_UDP,
                        16'h0000, MY_IP, r.src_ip};
            sum = 0;
            for (int w = 0; w < 10; w++) begin
                sum = sum + {16'h0, ip_words[16*w +: 16]};
            end
            push_field({r.src_mac, `LOCAL_MAC}, 12, 1);
            push_field({`ETHERTYPE_IPV4, 16'h4500, ip_len, 16'h0000}, 8, 1);
            push_field({16'h0000, `REPLY_TTL, `IP_PROTO_UDP, ~ones_fold(sum), MY_IP[31:16]}, 8, 1);
            push_field({MY_IP[15:0], r.src_ip, r.dst_port}, 8, 1);
            push_field({r.src_port, ip_len - 16'd20, 16'h0000}, 6, 1);
        end
        for (int k = 0; k < r.pay_len; k++) begin
            b.data = r.first_byte + 8'(k);
            b.last = (k == r.pay_len - 1);
            tx_q.push_back(b);
            if (r.echo) begin
                b.data = b.data + 8'd1;
                exp_q.push_back(b);
            end
        end
        ok = 1'b1;
        foreach (tx_q[i]) begin
            @(posedge clk_system);
            #2;
            in_beat = tx_q[i];
            in_valid = 1'b1;
            wait_cnt = 0;
            @(negedge clk_system);
            while (!in_ready && wait_cnt < READY_TIMEOUT) begin
                @(negedge clk_system);
                wait_cnt++;
            end
            if (!in_ready) begin
                $display("Timeout: byte %0d of frame %0d was never accepted", i, idx);
                other_errors++;
                ok = 1'b0;
                return;
            end
        end
    endtask

    initial begin
        lfsr = 32'h5619;
        out_ready = 1'b0;
        forever begin
            @(posedge clk_system);
            #2;
            lfsr = lfsr_next(lfsr);
            out_ready = lfsr[0];
        end
    end

    // Reply checker, also sums the reply IP header words
    initial begin : collect
        udp_echo_pkg::byte_beat_t exp_beat;
        int                       pos;
        logic [31:0]              sum;
        pos = 0;
        sum = 0;
        forever begin
            @(negedge clk_system);
            if (!rst && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected output byte 0x%0h with no reply pending", out_beat.data);
                    other_errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_value("out_beat.data", out_beat.data, exp_beat.data);
                    check_value("out_beat.last", out_beat.last, exp_beat.last);
                end
                if (pos >= 14 && pos <= 33) begin
                    sum = sum + (pos % 2 == 0 ? {16'h0, out_beat.data, 8'h0}
                                              : {24'h0, out_beat.data});
                end
                if (pos == 33) begin
                    check_value("ip_header_sum", ones_fold(sum), 32'hffff);
                end
                if (out_beat.last) begin
                    pos = 0;
                    sum = 0;
                end else begin
                    pos++;
                end
            end
        end
    end

    initial begin : run
        bit ok;
        int wait_cnt;
        rst = 1'b1;
        in_valid = 1'b0;
        in_beat = '0;
        add_row(48'h0a1b2c3d4e01, 32'hc0a8020a, MY_IP, 5001, 1234, 'h0800, 17, 8, 'hf8, 1);
        add_row(48'h0a1b2c3d4e01, 32'hc0a8020a, MY_IP, 5001, 1235, 'h0800, 17, 20, 'h00, 0);
        add_row(48'h0a1b2c3d4e01, 32'hc0a8020a, 32'hc0a80281, 5001, 1234, 'h0800, 17, 20, 0, 0);
        add_row(48'h0a1b2c3d4e01, 32'hc0a8020a, MY_IP, 5001, 1234, 'h86dd, 17, 20, 'h00, 0);
        add_row(48'h0a1b2c3d4e01, 32'hc0a8020a, MY_IP, 5001, 1234, 'h0800, 6, 20, 'h00, 0);
        add_row(48'h0a1b2c3d4e02, 32'h0a000001, MY_IP, 40000, 1234, 'h0800, 17, 1, 'h10, 1);
        add_row(48'h0a1b2c3d4e03, 32'hc0a8020b, MY_IP, 6000, 1234, 'h0800, 17, 300, 'h00, 1);
        add_row(48'h0a1b2c3d4e01, 32'hc0a8020a, MY_IP, 5001, 1234, 'h0800, 17, 64, 'hc0, 1);
        add_row(48'h0a1b2c3d4e03, 32'hc0a8020b, MY_IP, 6000, 80, 'h0800, 17, 300, 'h55, 0);
        add_row(48'h0a1b2c3d4e04, 32'h0a000002, MY_IP, 1234, 1234, 'h0800, 17, 257, 'h7f, 1);
        add_row(48'h0a1b2c3d4e05, 32'hac100001, MY_IP, 65535, 1234, 'h0800, 17, 300, 'h33, 1);
        repeat (16) @(posedge clk_system);
        #2;
        rst = 1'b0;
        repeat (20) begin
            @(negedge clk_system);
            check_value("out_valid", out_valid, 0);
        end
        ok = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            send_frame(rows[i], i, ok);
            if (!ok) break;
        end
        @(posedge clk_system);
        #2;
        in_valid = 1'b0;
        in_beat = '0;
        if (ok) begin
            wait_cnt = 0;
            while (exp_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT) begin
                @(negedge clk_system);
                wait_cnt++;
            end
            if (exp_q.size() != 0) begin
                $display("Timeout: %0d reply bytes never arrived", exp_q.size());
                other_errors++;
            end else begin
                // Quiet window to catch extra output
                repeat (100) @(negedge clk_system);
                check_value("out_valid", out_valid, 0);
            end
        end
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/udp_echo_top.sv ====
`timescale 1ns/1ps

module udp_echo_top (
    input  logic                     clk_system,
    input  logic                     rst,
    input  udp_echo_pkg::byte_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output udp_echo_pkg::byte_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    udp_echo_pkg::udp_hdr_t   dec_hdr;
    logic                     dec_hdr_valid;
    logic                     dec_hdr_ready;
    udp_echo_pkg::byte_beat_t dec_pay;
    logic                     dec_pay_valid;
    logic                     dec_pay_ready;
    udp_echo_pkg::udp_hdr_t   rep_hdr;
    logic                     rep_hdr_valid;
    logic                     rep_hdr_ready;
    udp_echo_pkg::byte_beat_t fifo_beat;
    logic                     fifo_valid;
    logic                     fifo_ready;

    frame_header_decode u_decode (
        .clk_system(clk_system), .rst(rst),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .dec_hdr(dec_hdr), .dec_hdr_valid(dec_hdr_valid), .dec_hdr_ready(dec_hdr_ready),
        .dec_pay(dec_pay), .dec_pay_valid(dec_pay_valid), .dec_pay_ready(dec_pay_ready)
    );

    echo_port_execute u_execute (
        .clk_system(clk_system), .rst(rst),
        .dec_hdr(dec_hdr), .dec_hdr_valid(dec_hdr_valid), .dec_hdr_ready(dec_hdr_ready),
        .dec_pay(dec_pay), .dec_pay_valid(dec_pay_valid), .dec_pay_ready(dec_pay_ready),
        .rep_hdr(rep_hdr), .rep_hdr_valid(rep_hdr_valid), .rep_hdr_ready(rep_hdr_ready),
        .fifo_beat(fifo_beat), .fifo_valid(fifo_valid), .fifo_ready(fifo_ready)
    );

    reply_frame_result u_result (
        .clk_system(clk_system), .rst(rst),
        .rep_hdr(rep_hdr), .rep_hdr_valid(rep_hdr_valid), .rep_hdr_ready(rep_hdr_ready),
        .fifo_beat(fifo_beat), .fifo_valid(fifo_valid), .fifo_ready(fifo_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

// ==== logic/reply_frame_result.sv ====
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module reply_frame_result (
    input  logic                     clk_system,
    input  logic                     rst,
    input  udp_echo_pkg::udp_hdr_t   rep_hdr,
    input  logic                     rep_hdr_valid,
    output logic                     rep_hdr_ready,
    input  udp_echo_pkg::byte_beat_t fifo_beat,
    input  logic                     fifo_valid,
    output logic                     fifo_ready,
    output udp_echo_pkg::byte_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    localparam int LAST_IDX = `HEADER_BYTES - 1;
    localparam logic [31:0] MY_IP = `LOCAL_IP;

    udp_echo_pkg::result_state_t state;
    udp_echo_pkg::udp_hdr_t      hdr_q;
    logic [5:0]                  byte_cnt;
    logic [15:0]                 csum_q;
    logic [15:0]                 csum_next;
    logic [31:0]                 csum_acc;
    logic [16:0]                 csum_fold;
    logic [8*`HEADER_BYTES-1:0]  reply_bytes;

    // IPv4 header checksum over the reply header words
    always_comb begin
        csum_acc = 32'h0000_4500
                 + {16'h0, rep_hdr.ip_total_len}
                 + {16'h0, `REPLY_TTL, `IP_PROTO_UDP}
                 + {16'h0, MY_IP[31:16]}
                 + {16'h0, MY_IP[15:0]}
                 + {16'h0, rep_hdr.ip_src[31:16]}
                 + {16'h0, rep_hdr.ip_src[15:0]};
        csum_fold = {1'b0, csum_acc[15:0]} + {1'b0, csum_acc[31:16]};
        csum_next = ~(csum_fold[15:0] + {15'h0, csum_fold[16]});
    end

    // Reply header, first byte on the wire in the top bits
    assign reply_bytes = {
        hdr_q.eth_src, `LOCAL_MAC, `ETHERTYPE_IPV4,
        8'h45, 8'h00, hdr_q.ip_total_len,
        16'h0000, 16'h0000,
        `REPLY_TTL, `IP_PROTO_UDP, csum_q,
        MY_IP, hdr_q.ip_src,
        hdr_q.dst_port, hdr_q.src_port, hdr_q.udp_len, 16'h0000
    };

    always_ff @(posedge clk_system) begin
        if (rst) begin
            state <= udp_echo_pkg::RS_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                udp_echo_pkg::RS_IDLE: begin
                    byte_cnt <= '0;
                    if (rep_hdr_valid) begin
                        state <= udp_echo_pkg::RS_HEADER;
                    end
                end
                udp_echo_pkg::RS_HEADER: begin
                    if (out_ready) begin
                        if (byte_cnt == 6'(LAST_IDX)) begin
                            byte_cnt <= '0;
                            state <= udp_echo_pkg::RS_PAYLOAD;
                        end else begin
                            byte_cnt <= byte_cnt + 6'd1;
                        end
                    end
                end
                default: begin
                    if (fifo_valid && out_ready && fifo_beat.last) begin
                        state <= udp_echo_pkg::RS_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_system) begin
        if (state == udp_echo_pkg::RS_IDLE && rep_hdr_valid) begin
            hdr_q <= rep_hdr;
            csum_q <= csum_next;
        end
    end

    assign rep_hdr_ready = state == udp_echo_pkg::RS_IDLE;
    assign fifo_ready = (state == udp_echo_pkg::RS_PAYLOAD) && out_ready;

    always_comb begin
        out_beat.data = reply_bytes[(LAST_IDX - int'(byte_cnt))*8 +: 8];
        out_beat.last = 1'b0;
        out_valid = 1'b0;
        case (state)
            udp_echo_pkg::RS_HEADER: out_valid = 1'b1;
            udp_echo_pkg::RS_PAYLOAD: begin
                out_beat = fifo_beat;
                out_valid = fifo_valid;
            end
            default: out_valid = 1'b0;
        endcase
    end

endmodule

// ==== logic/echo_port_execute.sv ====
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module echo_port_execute (
    input  logic                     clk_system,
    input  logic                     rst,
    input  udp_echo_pkg::udp_hdr_t   dec_hdr,
    input  logic                     dec_hdr_valid,
    output logic                     dec_hdr_ready,
    input  udp_echo_pkg::byte_beat_t dec_pay,
    input  logic                     dec_pay_valid,
    output logic                     dec_pay_ready,
    output udp_echo_pkg::udp_hdr_t   rep_hdr,
    output logic                     rep_hdr_valid,
    input  logic                     rep_hdr_ready,
    output udp_echo_pkg::byte_beat_t fifo_beat,
    output logic                     fifo_valid,
    input  logic                     fifo_ready
);

    localparam int DEPTH = 1 << `FIFO_ADDR_BITS;

    udp_echo_pkg::byte_beat_t mem [DEPTH];
    udp_echo_pkg::byte_beat_t inc_beat;
    udp_echo_pkg::udp_hdr_t   slot_q;
    logic [`FIFO_ADDR_BITS:0] wr_ptr;
    logic [`FIFO_ADDR_BITS:0] rd_ptr;
    logic [`FIFO_ADDR_BITS:0] fill;
    logic                     fifo_full;
    logic                     keep_q;
    logic                     hdr_match;
    logic                     hdr_fire;
    logic                     pay_fire;

    assign hdr_match = (dec_hdr.ip_dst == `LOCAL_IP) && (dec_hdr.dst_port == `ECHO_PORT);
    assign hdr_fire = dec_hdr_valid && dec_hdr_ready;
    assign pay_fire = dec_pay_valid && dec_pay_ready;

    // Single reply slot
    assign dec_hdr_ready = !rep_hdr_valid;
    assign rep_hdr = slot_q;

    assign fill = wr_ptr - rd_ptr;
    assign fifo_full = fill[`FIFO_ADDR_BITS];
    assign dec_pay_ready = !fifo_full;
    assign fifo_valid = wr_ptr != rd_ptr;
    assign fifo_beat = mem[rd_ptr[`FIFO_ADDR_BITS-1:0]];

    // Echo transform, 0xFF wraps to 0x00
    assign inc_beat.data = dec_pay.data + 8'd1;
    assign inc_beat.last = dec_pay.last;

    always_ff @(posedge clk_system) begin
        if (rst) begin
            keep_q <= 1'b0;
            rep_hdr_valid <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (hdr_fire) begin
                keep_q <= hdr_match;
                rep_hdr_valid <= hdr_match;
            end else if (rep_hdr_valid && rep_hdr_ready) begin
                rep_hdr_valid <= 1'b0;
            end
            if (pay_fire && dec_pay.last) begin
                keep_q <= 1'b0;
            end
            if (pay_fire && keep_q) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_valid && fifo_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_system) begin
        if (hdr_fire && hdr_match) begin
            slot_q <= dec_hdr;
        end
        if (pay_fire && keep_q) begin
            mem[wr_ptr[`FIFO_ADDR_BITS-1:0]] <= inc_beat;
        end
    end

endmodule

// ==== logic/frame_header_decode.sv ====
`timescale 1ns/1ps
`include "udp_echo_settings.svh"

module frame_header_decode (
    input  logic                     clk_system,
    input  logic                     rst,
    input  udp_echo_pkg::byte_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output udp_echo_pkg::udp_hdr_t   dec_hdr,
    output logic                     dec_hdr_valid,
    input  logic                     dec_hdr_ready,
    output udp_echo_pkg::byte_beat_t dec_pay,
    output logic                     dec_pay_valid,
    input  logic                     dec_pay_ready
);

    localparam logic [15:0] ETH_TYPE = `ETHERTYPE_IPV4;
    localparam logic [5:0] LAST_IDX = 6'(`HEADER_BYTES - 1);

    udp_echo_pkg::decode_state_t state;
    udp_echo_pkg::udp_hdr_t      hdr_q;
    logic [5:0]                  hdr_cnt;
    logic                        bad_q;
    logic                        byte_bad;
    logic                        in_fire;

    assign in_fire = in_valid && in_ready;
    assign dec_hdr = hdr_q;
    assign dec_pay = in_beat;

    // Fixed fields that must match, IHL 5 only
    always_comb begin
        case (hdr_cnt)
            6'd12: byte_bad = in_beat.data != ETH_TYPE[15:8];
            6'd13: byte_bad = in_beat.data != ETH_TYPE[7:0];
            6'd14: byte_bad = in_beat.data != 8'h45;
            6'd23: byte_bad = in_beat.data != `IP_PROTO_UDP;
            default: byte_bad = 1'b0;
        endcase
    end

    always_ff @(posedge clk_system) begin
        if (rst) begin
            state <= udp_echo_pkg::ST_HEADER;
            hdr_cnt <= '0;
            bad_q <= 1'b0;
            dec_hdr_valid <= 1'b0;
        end else begin
            if (dec_hdr_valid && dec_hdr_ready) begin
                dec_hdr_valid <= 1'b0;
            end
            case (state)
                udp_echo_pkg::ST_HEADER: begin
                    if (in_fire) begin
                        if (in_beat.last) begin
                            // Runt frame, nothing to report
                            hdr_cnt <= '0;
                            bad_q <= 1'b0;
                        end else if (hdr_cnt == LAST_IDX) begin
                            hdr_cnt <= '0;
                            bad_q <= 1'b0;
                            if (bad_q || byte_bad) begin
                                state <= udp_echo_pkg::ST_DROP;
                            end else begin
                                state <= udp_echo_pkg::ST_PAYLOAD;
                                dec_hdr_valid <= 1'b1;
                            end
                        end else begin
                            hdr_cnt <= hdr_cnt + 6'd1;
                            bad_q <= bad_q || byte_bad;
                        end
                    end
                end
                default: begin
                    if (in_fire && in_beat.last) begin
                        state <= udp_echo_pkg::ST_HEADER;
                    end
                end
            endcase
        end
    end

    // Field capture, big-endian shift into place
    always_ff @(posedge clk_system) begin
        if (in_fire && state == udp_echo_pkg::ST_HEADER) begin
            if (hdr_cnt inside {[6'd6:6'd11]}) begin
                hdr_q.eth_src <= {hdr_q.eth_src[39:0], in_beat.data};
            end
            if (hdr_cnt inside {[6'd16:6'd17]}) begin
                hdr_q.ip_total_len <= {hdr_q.ip_total_len[7:0], in_beat.data};
            end
            if (hdr_cnt inside {[6'd26:6'd29]}) begin
                hdr_q.ip_src <= {hdr_q.ip_src[23:0], in_beat.data};
            end
            if (hdr_cnt inside {[6'd30:6'd33]}) begin
                hdr_q.ip_dst <= {hdr_q.ip_dst[23:0], in_beat.data};
            end
            if (hdr_cnt inside {[6'd34:6'd35]}) begin
                hdr_q.src_port <= {hdr_q.src_port[7:0], in_beat.data};
            end
            if (hdr_cnt inside {[6'd36:6'd37]}) begin
                hdr_q.dst_port <= {hdr_q.dst_port[7:0], in_beat.data};
            end
            if (hdr_cnt inside {[6'd38:6'd39]}) begin
                hdr_q.udp_len <= {hdr_q.udp_len[7:0], in_beat.data};
            end
        end
    end

    // Payload is held back until the header has been taken
    always_comb begin
        in_ready = 1'b1;
        dec_pay_valid = 1'b0;
        if (state == udp_echo_pkg::ST_PAYLOAD) begin
            in_ready = dec_pay_ready && !dec_hdr_valid;
            dec_pay_valid = in_valid && !dec_hdr_valid;
        end
    end

endmodule

// ==== logic/udp_echo_pkg.sv ====
package udp_echo_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] len16_t;

    // One stream byte with its end-of-frame flag
    typedef struct packed {
        byte_t data;
        logic  last;
    } byte_beat_t;

    // Received fields needed to build the reply
    typedef struct packed {
        mac_addr_t eth_src;
        ip_addr_t  ip_src;
        ip_addr_t  ip_dst;
        len16_t    ip_total_len;
        udp_port_t src_port;
        udp_port_t dst_port;
        len16_t    udp_len;
    } udp_hdr_t;

    typedef enum logic [1:0] {
        ST_HEADER,
        ST_PAYLOAD,
        ST_DROP
    } decode_state_t;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_HEADER,
        RS_PAYLOAD
    } result_state_t;

endpackage

// ==== include/udp_echo_settings.svh ====
`ifndef UDP_ECHO_SETTINGS_SVH
`define UDP_ECHO_SETTINGS_SVH

// Local station identity
`define LOCAL_MAC 48'h02_00_00_00_00_00
`define LOCAL_IP 32'hC0_A8_02_80

// Echo service port
`define ECHO_PORT 16'd1234
`define REPLY_TTL 8'd64

// Protocol numbers
`define ETHERTYPE_IPV4 16'h0800
`define IP_PROTO_UDP 8'd17

// Ethernet 14 + IPv4 20 + UDP 8
`define HEADER_BYTES 42

// 2048-byte payload FIFO
`define FIFO_ADDR_BITS 11

`endif
